// ==== rtl/apb_soc_pkg.sv ====
// Shared APB bus structs, width types and slot map, imported by every block of the subsystem
`default_nettype none

package apb_soc_pkg;

   // Byte address and data word of the peripheral APB
   typedef logic [15:0] apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // PWM counter, period and compare values
   typedef logic [15:0] pwm_cnt_t;

   // Host to slave
   typedef struct packed {
      apb_addr_t paddr;
      logic      pwrite;
      apb_data_t pwdata;
      logic      psel;
      logic      penable;
   } apb_req_t;

   // Slave to host
   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

   // One 4 KiB slot per peripheral, 0x3000 left unmapped
   localparam apb_addr_t GPIO_BASE = 16'h0000;
   localparam apb_addr_t PWM_BASE  = 16'h1000;
   localparam apb_addr_t CTRL_BASE = 16'h2000;

   // Value of the read-only identification register
   localparam apb_data_t SOC_ID = 32'h50C1_A7E3;

endpackage

`default_nettype wire

// ==== rtl/periph_bus_decode.sv ====
// APB slot decoder that routes host requests to GPIO, PWM and SoC control and muxes replies
`default_nettype none
`timescale 1ns/1ps

module periph_bus_decode (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_soc_pkg::apb_req_t apb_req_i,
   output apb_soc_pkg::apb_rsp_t apb_rsp_o,
   output apb_soc_pkg::apb_req_t gpio_req_o,
   output apb_soc_pkg::apb_req_t pwm_req_o,
   output apb_soc_pkg::apb_req_t ctrl_req_o,
   input  apb_soc_pkg::apb_rsp_t gpio_rsp_i,
   input  apb_soc_pkg::apb_rsp_t pwm_rsp_i,
   input  apb_soc_pkg::apb_rsp_t ctrl_rsp_i
);

   import apb_soc_pkg::*;

   localparam logic [1:0] GPIO_SLOT = GPIO_BASE[13:12];
   localparam logic [1:0] PWM_SLOT  = PWM_BASE[13:12];
   localparam logic [1:0] CTRL_SLOT = CTRL_BASE[13:12];

   logic [1:0] slot;

   assign slot = apb_req_i.paddr[13:12];

   // Same request to every slave, only psel is steered
   always_comb begin
      gpio_req_o      = apb_req_i;
      pwm_req_o       = apb_req_i;
      ctrl_req_o      = apb_req_i;
      gpio_req_o.psel = apb_req_i.psel && (slot == GPIO_SLOT);
      pwm_req_o.psel  = apb_req_i.psel && (slot == PWM_SLOT);
      ctrl_req_o.psel = apb_req_i.psel && (slot == CTRL_SLOT);
   end

   always_comb begin
      case (slot)
         GPIO_SLOT: apb_rsp_o = gpio_rsp_i;
         PWM_SLOT:  apb_rsp_o = pwm_rsp_i;
         CTRL_SLOT: apb_rsp_o = ctrl_rsp_i;
         default: begin
            // Empty slot answers itself with an error
            apb_rsp_o.prdata  = '0;
            apb_rsp_o.pready  = 1'b1;
            apb_rsp_o.pslverr = apb_req_i.psel;
         end
      endcase
   end

   // Access phase only ever follows a select
   a_penable_psel: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      apb_req_i.penable |-> apb_req_i.psel
   ) else $error("penable without psel");

   // Host holds the request until the slave completes it
   a_req_stable: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      apb_req_i.psel && !(apb_req_i.penable && apb_rsp_o.pready) |=>
         apb_req_i.psel &&
         $stable(apb_req_i.paddr) &&
         $stable(apb_req_i.pwrite) &&
         $stable(apb_req_i.pwdata)
   ) else $error("APB request changed before pready");

endmodule

`default_nettype wire

// ==== rtl/apb_gpio.sv ====
// GPIO register block with direction, output, synchronized input and rising-edge interrupts
`default_nettype none
`timescale 1ns/1ps

module apb_gpio #(
   parameter int unsigned NUM_GPIO = 32
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_soc_pkg::apb_req_t apb_req_i,
   output apb_soc_pkg::apb_rsp_t apb_rsp_o,
   input  logic [NUM_GPIO-1:0]   gpio_in_i,
   output logic [NUM_GPIO-1:0]   gpio_out_o,
   output logic [NUM_GPIO-1:0]   gpio_oe_o,
   output logic                  gpio_irq_o
);

   import apb_soc_pkg::*;

   localparam logic [11:0] OFF_DIR    = 12'h000;
   localparam logic [11:0] OFF_OUT    = 12'h004;
   localparam logic [11:0] OFF_IN     = 12'h008;
   localparam logic [11:0] OFF_STATUS = 12'h00C;
   localparam logic [11:0] OFF_MASK   = 12'h010;

   typedef logic [NUM_GPIO-1:0] gpio_vec_t;

   gpio_vec_t   dir_q;
   gpio_vec_t   out_q;
   gpio_vec_t   mask_q;
   gpio_vec_t   status_q;
   gpio_vec_t   sync1_q;
   gpio_vec_t   sync2_q;
   gpio_vec_t   prev_q;
   gpio_vec_t   rise;
   gpio_vec_t   wdata;
   logic [11:0] offset;
   logic        wr_en;
   logic        bad_addr;
   apb_data_t   rdata;

   assign offset = apb_req_i.paddr[11:0];
   assign wr_en  = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite && !bad_addr;
   assign wdata  = apb_req_i.pwdata[NUM_GPIO-1:0];
   assign rise   = sync2_q & ~prev_q;

   always_comb begin
      rdata    = '0;
      bad_addr = 1'b0;
      case (offset)
         OFF_DIR:    rdata = apb_data_t'(dir_q);
         OFF_OUT:    rdata = apb_data_t'(out_q);
         OFF_IN:     rdata = apb_data_t'(sync2_q);
         OFF_STATUS: rdata = apb_data_t'(status_q);
         OFF_MASK:   rdata = apb_data_t'(mask_q);
         default:    bad_addr = 1'b1;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         dir_q    <= '0;
         out_q    <= '0;
         mask_q   <= '0;
         status_q <= '0;
         sync1_q  <= '0;
         sync2_q  <= '0;
         prev_q   <= '0;
      end else begin
         // Two-flop synchronizer, then edge detect on the clean value
         sync1_q <= gpio_in_i;
         sync2_q <= sync1_q;
         prev_q  <= sync2_q;
         if (wr_en && offset == OFF_DIR) dir_q <= wdata;
         if (wr_en && offset == OFF_OUT) out_q <= wdata;
         if (wr_en && offset == OFF_MASK) mask_q <= wdata;
         // New edges win over a clear in the same cycle
         if (wr_en && offset == OFF_STATUS) begin
            status_q <= (status_q & ~wdata) | rise;
         end else begin
            status_q <= status_q | rise;
         end
      end
   end

   assign gpio_oe_o  = dir_q;
   assign gpio_out_o = out_q;
   assign gpio_irq_o = |(status_q & mask_q);

   assign apb_rsp_o.prdata  = rdata;
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = apb_req_i.psel && bad_addr;

   a_err_with_ready: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      apb_rsp_o.pslverr |-> apb_rsp_o.pready
   ) else $error("GPIO pslverr without pready");

endmodule

`default_nettype wire

// ==== rtl/apb_pwm_timer.sv ====
// PWM timer with one free-running period counter and a compare register per output channel
`default_nettype none
`timescale 1ns/1ps

module apb_pwm_timer #(
   parameter int unsigned NUM_CH = 4
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_soc_pkg::apb_req_t apb_req_i,
   output apb_soc_pkg::apb_rsp_t apb_rsp_o,
   output logic [NUM_CH-1:0]     pwm_o,
   output logic                  pwm_evt_o
);

   import apb_soc_pkg::*;

   localparam logic [11:0] OFF_CTRL   = 12'h000;
   localparam logic [11:0] OFF_PERIOD = 12'h004;
   localparam logic [11:0] OFF_COUNT  = 12'h008;
   localparam logic [11:0] OFF_CMP    = 12'h010;

   logic                     enable_q;
   pwm_cnt_t                 period_q;
   pwm_cnt_t                 count_q;
   pwm_cnt_t [NUM_CH-1:0]    cmp_q;
   logic [11:0]              offset;
   logic [11:0]              cmp_off;
   logic [2:0]               cmp_idx;
   logic                     is_cmp;
   logic                     wr_en;
   logic                     bad_addr;
   apb_data_t                rdata;

   assign offset  = apb_req_i.paddr[11:0];
   assign cmp_off = offset - OFF_CMP;
   assign cmp_idx = cmp_off[4:2];
   // Word-aligned slot inside the channel window
   assign is_cmp  = (offset >= OFF_CMP) && (offset[1:0] == 2'b00) &&
                    (cmp_off[11:2] < 10'(NUM_CH));
   assign wr_en   = apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite && !bad_addr;

   always_comb begin
      rdata    = '0;
      bad_addr = 1'b0;
      if (is_cmp) begin
         rdata = apb_data_t'(cmp_q[cmp_idx]);
      end else begin
         case (offset)
            OFF_CTRL:   rdata = apb_data_t'(enable_q);
            OFF_PERIOD: rdata = apb_data_t'(period_q);
            OFF_COUNT:  rdata = apb_data_t'(count_q);
            default:    bad_addr = 1'b1;
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         enable_q <= 1'b0;
         period_q <= '0;
         count_q  <= '0;
         cmp_q    <= '0;
      end else begin
         if (wr_en && offset == OFF_CTRL) enable_q <= apb_req_i.pwdata[0];
         if (wr_en && offset == OFF_PERIOD) period_q <= apb_req_i.pwdata[15:0];
         for (int ch = 0; ch < NUM_CH; ch++) begin
            if (wr_en && is_cmp && cmp_idx == 3'(ch)) cmp_q[ch] <= apb_req_i.pwdata[15:0];
         end
         // Wrap also covers a period lowered below the running count
         if (!enable_q || count_q >= period_q) begin
            count_q <= '0;
         end else begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   always_comb begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
         pwm_o[ch] = enable_q && (count_q < cmp_q[ch]);
      end
   end

   assign pwm_evt_o = enable_q && (count_q == period_q);

   assign apb_rsp_o.prdata  = rdata;
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = apb_req_i.psel && bad_addr;

   a_count_in_period: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      enable_q && $stable(period_q) |-> count_q <= period_q
   ) else $error("PWM counter beyond period");

endmodule

`default_nettype wire

// ==== rtl/apb_soc_control.sv ====
// SoC control registers for cluster reset, fetch enable, boot mode, scratch and chip ID
`default_nettype none
`timescale 1ns/1ps

module apb_soc_control (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_soc_pkg::apb_req_t apb_req_i,
   output apb_soc_pkg::apb_rsp_t apb_rsp_o,
   output logic                  cluster_rstn_o,
   output logic                  cluster_fetch_en_o,
   output logic                  cluster_sa_boot_o
);

   import apb_soc_pkg::*;

   localparam logic [11:0] OFF_CLUSTER = 12'h000;
   localparam logic [11:0] OFF_SCRATCH = 12'h004;
   localparam logic [11:0] OFF_ID      = 12'h008;

   logic [2:0]  cluster_q;
   apb_data_t   scratch_q;
   logic [11:0] offset;
   logic        access;
   logic        wr_en;
   logic        bad_addr;
   apb_data_t   rdata;

   assign offset = apb_req_i.paddr[11:0];
   assign access = apb_req_i.psel && apb_req_i.penable;
   assign wr_en  = access && apb_req_i.pwrite && !bad_addr;

   always_comb begin
      rdata    = '0;
      bad_addr = 1'b0;
      case (offset)
         OFF_CLUSTER: rdata = apb_data_t'(cluster_q);
         OFF_SCRATCH: rdata = scratch_q;
         OFF_ID: begin
            rdata    = apb_req_i.pwrite ? '0 : SOC_ID;
            bad_addr = apb_req_i.pwrite;
         end
         default: bad_addr = 1'b1;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cluster_q <= '0;
         scratch_q <= '0;
      end else begin
         if (wr_en && offset == OFF_CLUSTER) cluster_q <= apb_req_i.pwdata[2:0];
         if (wr_en && offset == OFF_SCRATCH) scratch_q <= apb_req_i.pwdata;
      end
   end

   // No fetch while the cluster is held in reset
   assign cluster_rstn_o     = cluster_q[0];
   assign cluster_fetch_en_o = cluster_q[1] && cluster_q[0];
   assign cluster_sa_boot_o  = cluster_q[2];

   assign apb_rsp_o.prdata  = rdata;
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = apb_req_i.psel && bad_addr;

   a_fetch_needs_rstn: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      cluster_fetch_en_o |-> cluster_rstn_o
   ) else $error("fetch enable while cluster in reset");

endmodule

`default_nettype wire

// ==== rtl/apb_subsystem.sv ====
// Top of the APB peripheral subsystem, wiring the slot decoder to GPIO, PWM and SoC control
`default_nettype none
`timescale 1ns/1ps

module apb_subsystem #(
   parameter int unsigned NUM_GPIO = 32,
   parameter int unsigned NUM_CH   = 4
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  apb_soc_pkg::apb_req_t apb_req_i,
   output apb_soc_pkg::apb_rsp_t apb_rsp_o,

   input  logic [NUM_GPIO-1:0]   gpio_in_i,
   output logic [NUM_GPIO-1:0]   gpio_out_o,
   output logic [NUM_GPIO-1:0]   gpio_oe_o,
   output logic                  gpio_irq_o,

   output logic [NUM_CH-1:0]     pwm_o,
   output logic                  pwm_evt_o,

   output logic                  cluster_rstn_o,
   output logic                  cluster_fetch_en_o,
   output logic                  cluster_sa_boot_o
);

   import apb_soc_pkg::*;

   apb_req_t gpio_req;
   apb_req_t pwm_req;
   apb_req_t ctrl_req;
   apb_rsp_t gpio_rsp;
   apb_rsp_t pwm_rsp;
   apb_rsp_t ctrl_rsp;

   periph_bus_decode i_periph_bus_decode (
      .clk_i      ( clk_i     ),
      .rst_n_i    ( rst_n_i   ),
      .apb_req_i  ( apb_req_i ),
      .apb_rsp_o  ( apb_rsp_o ),
      .gpio_req_o ( gpio_req  ),
      .pwm_req_o  ( pwm_req   ),
      .ctrl_req_o ( ctrl_req  ),
      .gpio_rsp_i ( gpio_rsp  ),
      .pwm_rsp_i  ( pwm_rsp   ),
      .ctrl_rsp_i ( ctrl_rsp  )
   );

   apb_gpio #(
      .NUM_GPIO ( NUM_GPIO )
   ) i_apb_gpio (
      .clk_i      ( clk_i      ),
      .rst_n_i    ( rst_n_i    ),
      .apb_req_i  ( gpio_req   ),
      .apb_rsp_o  ( gpio_rsp   ),
      .gpio_in_i  ( gpio_in_i  ),
      .gpio_out_o ( gpio_out_o ),
      .gpio_oe_o  ( gpio_oe_o  ),
      .gpio_irq_o ( gpio_irq_o )
   );

   apb_pwm_timer #(
      .NUM_CH ( NUM_CH )
   ) i_apb_pwm_timer (
      .clk_i     ( clk_i     ),
      .rst_n_i   ( rst_n_i   ),
      .apb_req_i ( pwm_req   ),
      .apb_rsp_o ( pwm_rsp   ),
      .pwm_o     ( pwm_o     ),
      .pwm_evt_o ( pwm_evt_o )
   );

   apb_soc_control i_apb_soc_control (
      .clk_i              ( clk_i              ),
      .rst_n_i            ( rst_n_i            ),
      .apb_req_i          ( ctrl_req           ),
      .apb_rsp_o          ( ctrl_rsp           ),
      .cluster_rstn_o     ( cluster_rstn_o     ),
      .cluster_fetch_en_o ( cluster_fetch_en_o ),
      .cluster_sa_boot_o  ( cluster_sa_boot_o  )
   );

endmodule

`default_nettype wire

// ==== bench/tb_apb_checks.svh ====
// Compare tasks and error counters of the APB subsystem testbench, included in its top module
`ifndef TB_APB_CHECKS_SVH
`define TB_APB_CHECKS_SVH

   int error_count = 0;
   int check_count = 0;

   task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic check_err(input string name, input logic got, input logic exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_cnt(input string name, input pwm_cnt_t got, input pwm_cnt_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("** Error: %s = 0x%04h, expected 0x%04h", name, got, exp);
      end
   endtask

`endif

// ==== bench/tb_apb_subsystem.sv ====
// Self-checking testbench that drives the APB host port and checks GPIO, PWM and SoC control
`default_nettype none
`timescale 1ns/1ps

module tb_apb_subsystem;

   import apb_soc_pkg::*;

   localparam int unsigned NUM_GPIO = 32;
   localparam int unsigned NUM_CH   = 4;
   localparam int          TIMEOUT  = 50;

   logic                clk;
   logic                rst_n;
   apb_req_t            apb_req;
   apb_rsp_t            apb_rsp;
   logic [NUM_GPIO-1:0] gpio_in;
   logic [NUM_GPIO-1:0] gpio_out;
   logic [NUM_GPIO-1:0] gpio_oe;
   logic                gpio_irq;
   logic [NUM_CH-1:0]   pwm;
   logic                pwm_evt;
   logic                cluster_rstn;
   logic                cluster_fetch_en;
   logic                cluster_sa_boot;
   int                  seed = 15257;
   apb_data_t           dir_m;
   apb_data_t           out_m;
   apb_data_t           scratch_m;

   `include "tb_apb_checks.svh"

   apb_subsystem apb_subsystem_i (
      .clk_i              ( clk              ),
      .rst_n_i            ( rst_n            ),
      .apb_req_i          ( apb_req          ),
      .apb_rsp_o          ( apb_rsp          ),
      .gpio_in_i          ( gpio_in          ),
      .gpio_out_o         ( gpio_out         ),
      .gpio_oe_o          ( gpio_oe          ),
      .gpio_irq_o         ( gpio_irq         ),
      .pwm_o              ( pwm              ),
      .pwm_evt_o          ( pwm_evt          ),
      .cluster_rstn_o     ( cluster_rstn     ),
      .cluster_fetch_en_o ( cluster_fetch_en ),
      .cluster_sa_boot_o  ( cluster_sa_boot  )
   );

   always #5 clk = ~clk;

   // Written value as seen through the implemented GPIO bits
   function automatic apb_data_t gpio_write_mask(input apb_data_t value);
      apb_data_t mask;
      mask = '0;
      for (int b = 0; b < NUM_GPIO; b++) mask[b] = 1'b1;
      return value & mask;
   endfunction

   function automatic apb_data_t expected_readback(input apb_addr_t addr, input apb_data_t value);
      if (addr[13:12] == GPIO_BASE[13:12]) return gpio_write_mask(value);
      if (addr == CTRL_BASE) return value & 32'h7;
      return value;
   endfunction

   function automatic pwm_cnt_t expected_duty(input pwm_cnt_t cmp, input pwm_cnt_t period);
      return (cmp > period) ? period + 16'd1 : cmp;
   endfunction

   // Bits are sa_boot, fetch_en, rstn
   function automatic logic [2:0] expected_cluster(input apb_data_t value);
      return {value[2], value[1] & value[0], value[0]};
   endfunction

   task automatic abort_run(input string why);
      $display("Timeout: %s", why);
      $display("Checks: %0d  Errors: %0d", check_count, error_count);
      $display("Some tests failed");
      $finish;
   endtask

   task automatic apb_xfer(input apb_addr_t addr, input logic write, input apb_data_t wdata,
                           output apb_data_t rdata, output logic err);
      int cycles;
      cycles = 0;
      @(posedge clk);
      apb_req.paddr   <= addr;
      apb_req.pwrite  <= write;
      apb_req.pwdata  <= wdata;
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      while (!apb_rsp.pready) begin
         if (cycles >= TIMEOUT) begin
            abort_run($sformatf("no pready at address 0x%04h", addr));
         end else begin
            cycles++;
            @(negedge clk);
         end
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
      apb_data_t unused;
      apb_xfer(addr, 1'b1, data, unused, err);
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
      apb_xfer(addr, 1'b0, '0, data, err);
   endtask

   task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
      logic err;
      apb_write(addr, data, err);
      check_err($sformatf("pslverr wr 0x%04h", addr), err, 1'b0);
   endtask

   task automatic read_check(input apb_addr_t addr, input apb_data_t exp);
      apb_data_t rd;
      logic      err;
      apb_read(addr, rd, err);
      check_data($sformatf("prdata 0x%04h", addr), rd, exp);
      check_err($sformatf("pslverr rd 0x%04h", addr), err, 1'b0);
   endtask

   task automatic expect_error(input apb_addr_t addr, input logic write, input apb_data_t data);
      apb_data_t rd;
      logic      err;
      apb_xfer(addr, write, data, rd, err);
      check_err($sformatf("pslverr 0x%04h", addr), err, 1'b1);
      check_data($sformatf("prdata 0x%04h", addr), rd, '0);
   endtask

   task automatic test_reset();
      apb_addr_t zero_regs[$];
      zero_regs = '{GPIO_BASE, GPIO_BASE | 16'h4, GPIO_BASE | 16'h8, GPIO_BASE | 16'hC,
                    GPIO_BASE | 16'h10, PWM_BASE, PWM_BASE | 16'h4, PWM_BASE | 16'h8,
                    PWM_BASE | 16'h10, PWM_BASE | 16'h14, PWM_BASE | 16'h18,
                    PWM_BASE | 16'h1C, CTRL_BASE, CTRL_BASE | 16'h4};
      @(negedge clk);
      check_data("gpio_oe_o", apb_data_t'(gpio_oe), '0);
      check_data("gpio_out_o", apb_data_t'(gpio_out), '0);
      check_data("pwm_o", apb_data_t'(pwm), '0);
      check_bit("pwm_evt_o", pwm_evt, 1'b0);
      check_bit("gpio_irq_o", gpio_irq, 1'b0);
      check_bit("cluster_rstn_o", cluster_rstn, 1'b0);
      check_bit("cluster_fetch_en_o", cluster_fetch_en, 1'b0);
      check_bit("cluster_sa_boot_o", cluster_sa_boot, 1'b0);
      foreach (zero_regs[i]) read_check(zero_regs[i], '0);
      read_check(CTRL_BASE | 16'h8, SOC_ID);
   endtask

   task automatic test_readback();
      apb_addr_t addr;
      apb_data_t value;
      int        pick;
      repeat (12) begin
         pick  = $unsigned($random(seed)) % 3;
         addr  = (pick == 0) ? GPIO_BASE : (pick == 1) ? (GPIO_BASE | 16'h4) : (CTRL_BASE | 16'h4);
         value = $random(seed);
         write_reg(addr, value);
         if (pick == 0) dir_m = expected_readback(addr, value);
         if (pick == 1) out_m = expected_readback(addr, value);
         if (pick == 2) scratch_m = expected_readback(addr, value);
         read_check(addr, expected_readback(addr, value));
         @(negedge clk);
         check_data("gpio_oe_o", apb_data_t'(gpio_oe), dir_m);
         check_data("gpio_out_o", apb_data_t'(gpio_out), out_m);
      end
   endtask

   task automatic test_gpio_input();
      apb_data_t pattern;
      apb_data_t rd;
      logic      err;
      int        tries;
      pattern = gpio_write_mask($random(seed) | 32'h8);
      write_reg(GPIO_BASE | 16'h10, 32'h8);
      @(posedge clk);
      gpio_in <= pattern[NUM_GPIO-1:0];
      tries = 0;
      apb_read(GPIO_BASE | 16'h8, rd, err);
      while (rd !== pattern) begin
         if (tries >= TIMEOUT) begin
            abort_run("GPIO IN never matched the driven pins");
         end else begin
            tries++;
            apb_read(GPIO_BASE | 16'h8, rd, err);
         end
      end
      check_err("pslverr rd IN", err, 1'b0);
      tries = 0;
      @(negedge clk);
      while (gpio_irq !== 1'b1) begin
         if (tries >= TIMEOUT) begin
            abort_run("gpio_irq_o never rose");
         end else begin
            tries++;
            @(negedge clk);
         end
      end
      read_check(GPIO_BASE | 16'hC, pattern);
      write_reg(GPIO_BASE | 16'hC, 32'h8);
      @(negedge clk);
      check_bit("gpio_irq_o", gpio_irq, 1'b0);
      read_check(GPIO_BASE | 16'hC, pattern & ~32'h8);
   endtask

   task automatic test_pwm();
      pwm_cnt_t period;
      pwm_cnt_t cmp  [NUM_CH];
      pwm_cnt_t high [NUM_CH];
      int       gap;
      period = 16'd9;
      write_reg(PWM_BASE | 16'h4, apb_data_t'(period));
      for (int ch = 0; ch < NUM_CH; ch++) begin
         // Last channel lands above the period
         cmp[ch]  = pwm_cnt_t'(ch * 4);
         high[ch] = '0;
         write_reg(PWM_BASE + apb_addr_t'(16 + 4 * ch), apb_data_t'(cmp[ch]));
      end
      write_reg(PWM_BASE, 32'h1);
      gap = 0;
      @(negedge clk);
      while (!pwm_evt) begin
         if (gap >= TIMEOUT) begin
            abort_run("no pwm_evt_o strobe after enable");
         end else begin
            gap++;
            @(negedge clk);
         end
      end
      gap = 0;
      do begin
         if (gap >= TIMEOUT) begin
            abort_run("second pwm_evt_o strobe missing");
         end else begin
            @(negedge clk);
            gap++;
            for (int ch = 0; ch < NUM_CH; ch++) if (pwm[ch]) high[ch] = high[ch] + 16'd1;
         end
      end while (!pwm_evt);
      check_cnt("pwm_evt_o spacing", pwm_cnt_t'(gap), period + 16'd1);
      for (int ch = 0; ch < NUM_CH; ch++) begin
         check_cnt($sformatf("pwm_o[%0d] high", ch), high[ch], expected_duty(cmp[ch], period));
      end
      write_reg(PWM_BASE, 32'h0);
      @(negedge clk);
      check_data("pwm_o", apb_data_t'(pwm), '0);
      read_check(PWM_BASE | 16'h8, '0);
   endtask

   task automatic test_cluster();
      logic [2:0] exp;
      for (int v = 0; v < 8; v++) begin
         write_reg(CTRL_BASE, apb_data_t'(v));
         exp = expected_cluster(apb_data_t'(v));
         @(negedge clk);
         check_bit("cluster_rstn_o", cluster_rstn, exp[0]);
         check_bit("cluster_fetch_en_o", cluster_fetch_en, exp[1]);
         check_bit("cluster_sa_boot_o", cluster_sa_boot, exp[2]);
         read_check(CTRL_BASE, expected_readback(CTRL_BASE, apb_data_t'(v)));
      end
   endtask

   task automatic test_errors();
      expect_error(16'h3000, 1'b0, '0);
      expect_error(16'h3004, 1'b1, $random(seed));
      expect_error(GPIO_BASE | 16'h14, 1'b1, '1);
      expect_error(GPIO_BASE | 16'h14, 1'b0, '0);
      expect_error(PWM_BASE | 16'hC, 1'b1, '1);
      expect_error(PWM_BASE | 16'h20, 1'b1, '1);
      expect_error(CTRL_BASE | 16'hC, 1'b0, '0);
      expect_error(CTRL_BASE | 16'h8, 1'b1, '0);
      read_check(GPIO_BASE, dir_m);
      read_check(GPIO_BASE | 16'h4, out_m);
      read_check(GPIO_BASE | 16'h10, 32'h8);
      read_check(PWM_BASE | 16'h4, 32'd9);
      read_check(PWM_BASE | 16'h10, 32'd0);
      read_check(PWM_BASE | 16'h1C, 32'd12);
      read_check(CTRL_BASE, 32'h7);
      read_check(CTRL_BASE | 16'h4, scratch_m);
      read_check(CTRL_BASE | 16'h8, SOC_ID);
   endtask

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      apb_req   = '0;
      gpio_in   = '0;
      dir_m     = '0;
      out_m     = '0;
      scratch_m = '0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      test_reset();
      test_readback();
      test_gpio_input();
      test_pwm();
      test_cluster();
      test_errors();
      $display("Checks: %0d  Errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+bench
rtl/apb_soc_pkg.sv
rtl/periph_bus_decode.sv
rtl/apb_gpio.sv
rtl/apb_pwm_timer.sv
rtl/apb_soc_control.sv
rtl/apb_subsystem.sv
bench/tb_apb_subsystem.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_apb_subsystem \
   -f verilog.f -Mdir obj_dir -o sim
./obj_dir/sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "Some tests failed" sim.log; then
   exit 1
fi
